// ==== include/fpm_defs.svh ====
`ifndef FPM_DEFS_SVH
`define FPM_DEFS_SVH

// exponent width, without the two extension bits
`define FPM_EXP_W 8

// alignment counter width
`define FPM_FIC_W 6

// mantissa length, shifts at or above this are pointless
`define FPM_ALIGN_LIMIT 40

`endif

// ==== sources.f ====
+incdir+include
src/fpm_pkg.sv
src/fpm_exp_if.sv
src/fpm_decoder.sv
src/fpm_exponent.sv
src/fic_counter.sv
src/fpm_seq.sv
src/fpm.sv
tests/fpm_props.sv
tests/fpm_tb.sv

// ==== src/fic_counter.sv ====
`timescale 1ns/1ps
`include "fpm_defs.svh"

module fic_counter #(
	parameter int width = `FPM_FIC_W
) (
	input logic f2strob,
	input logic _0_d_,
	input logic load,
	input logic [width-1:0] value,
	input logic count_en,
	input logic count_up,
	output logic fic_nz
);

	logic [width-1:0] cnt;

	// load wins over counting
	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= value;
		end else if (count_en) begin
			if (count_up) begin
				cnt <= cnt + 1'b1;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	assign fic_nz = |cnt;

endmodule

// ==== src/fpm.sv ====
`timescale 1ns/1ps
`include "fpm_defs.svh"

module fpm (
	input logic f2strob,
	input logic _0_d_,
	input logic start,
	input logic [0:2] ir,
	input logic pufa,
	input logic lkb,
	input logic [7:0] w,
	output logic [7:0] d,
	output logic d_1,
	output logic d_2,
	output logic g,
	output logic wdt,
	output logic v_f,
	output logic z_f,
	output logic m_f,
	output logic af_sf,
	output logic mw_mf,
	output logic dw_df,
	output logic ad_sd,
	output logic op_end
);
	import fpm_pkg::*;

	fp_op_t op;
	logic fic_load;
	logic count_en;
	logic count_up;
	logic fic_nz;

	fpm_exp_if exp_bus ();

	fpm_decoder u_decoder (
		.f2strob (f2strob),
		._0_d_ (_0_d_),
		.start (start),
		.ir (ir),
		.pufa (pufa),
		.op (op),
		.af_sf (af_sf),
		.mw_mf (mw_mf),
		.dw_df (dw_df),
		.ad_sd (ad_sd)
	);

	fpm_seq u_seq (
		.f2strob (f2strob),
		._0_d_ (_0_d_),
		.start (start),
		.pufa (pufa),
		.lkb (lkb),
		.op (op),
		.wdt (wdt),
		.fic_nz (fic_nz),
		.bus (exp_bus.seq),
		.fic_load (fic_load),
		.count_en (count_en),
		.count_up (count_up),
		.op_end (op_end)
	);

	fpm_exponent u_exponent (
		.f2strob (f2strob),
		._0_d_ (_0_d_),
		.w (w),
		.op (op),
		.bus (exp_bus.exp),
		.d (d),
		.d_1 (d_1),
		.d_2 (d_2),
		.g (g),
		.wdt (wdt),
		.v_f (v_f),
		.z_f (z_f),
		.m_f (m_f)
	);

	// alignment counter loads straight from the adder low bits
	fic_counter #(
		.width (`FPM_FIC_W)
	) u_fic (
		.f2strob (f2strob),
		._0_d_ (_0_d_),
		.load (fic_load),
		.value (exp_bus.diff_low),
		.count_en (count_en),
		.count_up (count_up),
		.fic_nz (fic_nz)
	);

endmodule

// ==== src/fpm_decoder.sv ====
`timescale 1ns/1ps

module fpm_decoder (
	input logic f2strob,
	input logic _0_d_,
	input logic start,
	input logic [0:2] ir,
	input logic pufa,
	output fpm_pkg::fp_op_t op,
	output logic af_sf,
	output logic mw_mf,
	output logic dw_df,
	output logic ad_sd
);
	import fpm_pkg::*;

	// opcode held until the next accepted start
	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			op <= OP_NONE;
		end else if (start && pufa) begin
			// ir[0] is the msb of the op number
			op <= fp_op_t'({1'b0, ir});
		end
	end

	// group lines, fixed and float variants paired
	always_comb begin
		af_sf = 1'b0;
		mw_mf = 1'b0;
		dw_df = 1'b0;
		ad_sd = 1'b0;
		case (op)
			OP_AD, OP_SD: ad_sd = 1'b1;
			OP_MW, OP_MF: mw_mf = 1'b1;
			OP_DW, OP_DF: dw_df = 1'b1;
			OP_AF, OP_SF: af_sf = 1'b1;
			default: ;
		endcase
	end

endmodule

// ==== src/fpm_exp_if.sv ====
`timescale 1ns/1ps
`include "fpm_defs.svh"

interface fpm_exp_if;
	import fpm_pkg::*;

	logic load_d;
	logic move_b;
	logic exec;
	b_bus_t bus_mode;
	logic carry_in;
	logic [`FPM_FIC_W-1:0] diff_low;
	logic over_limit;

	modport seq (output load_d, move_b, exec, bus_mode, carry_in, input diff_low, over_limit);
	modport exp (input load_d, move_b, exec, bus_mode, carry_in, output diff_low, over_limit);

endinterface

// ==== src/fpm_exponent.sv ====
`timescale 1ns/1ps
`include "fpm_defs.svh"

module fpm_exponent (
	input logic f2strob,
	input logic _0_d_,
	input logic [7:0] w,
	input fpm_pkg::fp_op_t op,
	fpm_exp_if.exp bus,
	output logic [7:0] d,
	output logic d_1,
	output logic d_2,
	output logic g,
	output logic wdt,
	output logic v_f,
	output logic z_f,
	output logic m_f
);
	import fpm_pkg::*;

	logic [`FPM_EXP_W-1:0] b_reg;
	logic [`FPM_EXP_W+1:0] d_ext;
	logic [`FPM_EXP_W+1:0] b_ext;
	logic [`FPM_EXP_W+1:0] b_bus;
	logic [`FPM_EXP_W+1:0] sum;
	logic [`FPM_EXP_W+1:0] l_bus;
	logic [`FPM_EXP_W+1:0] mag;
	logic is_af_sf;
	logic sum_ovf;

	assign is_af_sf = (op == OP_AF) || (op == OP_SF);

	// D with its two extension bits on top
	assign d_ext = {d_2, d_1, d};
	assign b_ext = {{2{b_reg[`FPM_EXP_W-1]}}, b_reg};

	always_comb begin
		case (bus.bus_mode)
			BB_INV: b_bus = ~b_ext;
			BB_TRUE: b_bus = b_ext;
			BB_ONES: b_bus = '1;
			default: b_bus = '0;
		endcase
	end

	// three-input exponent adder
	assign sum = b_bus + d_ext + {{(`FPM_EXP_W+1){1'b0}}, bus.carry_in};

	// L bus, w sign-extended on a load, else the adder
	assign l_bus = bus.load_d ? {{2{w[`FPM_EXP_W-1]}}, w} : sum;

	// difference magnitude for the alignment limit
	assign mag = sum[`FPM_EXP_W+1] ? -sum : sum;
	assign bus.over_limit = (mag >= `FPM_ALIGN_LIMIT);
	assign bus.diff_low = sum[`FPM_FIC_W-1:0];

	// extension bits disagree with the exponent sign
	assign sum_ovf = !((sum[`FPM_EXP_W+1] == sum[`FPM_EXP_W]) &&
		(sum[`FPM_EXP_W] == sum[`FPM_EXP_W-1]));

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			{d_2, d_1, d} <= '0;
		end else if (bus.load_d || bus.exec) begin
			{d_2, d_1, d} <= l_bus;
		end
	end

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			b_reg <= '0;
		end else if (bus.move_b) begin
			b_reg <= d;
		end
	end

	// flags and alignment state, taken at exec only
	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			g <= 1'b0;
			wdt <= 1'b0;
			v_f <= 1'b0;
			z_f <= 1'b0;
			m_f <= 1'b0;
		end else if (bus.exec) begin
			g <= is_af_sf && bus.over_limit;
			// shift direction: negative difference counts up
			wdt <= is_af_sf && sum[`FPM_EXP_W+1];
			v_f <= !is_af_sf && sum_ovf;
			z_f <= (sum == '0);
			m_f <= sum[`FPM_EXP_W+1];
		end
	end

endmodule

// ==== src/fpm_pkg.sv ====
package fpm_pkg;

	// opcode order follows ir, ad first
	typedef enum logic [3:0] {
		OP_AD,
		OP_SD,
		OP_MW,
		OP_DW,
		OP_AF,
		OP_SF,
		OP_MF,
		OP_DF,
		OP_NONE
	} fp_op_t;

	// B bus source
	typedef enum logic [1:0] {
		BB_INV,
		BB_TRUE,
		BB_ONES,
		BB_ZERO
	} b_bus_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_WAIT_A,
		S_MOVE_B,
		S_WAIT_B,
		S_EXEC,
		S_ALIGN,
		S_END
	} seq_state_t;

endpackage

// ==== src/fpm_seq.sv ====
`timescale 1ns/1ps

module fpm_seq (
	input logic f2strob,
	input logic _0_d_,
	input logic start,
	input logic pufa,
	input logic lkb,
	input fpm_pkg::fp_op_t op,
	input logic wdt,
	input logic fic_nz,
	fpm_exp_if.seq bus,
	output logic fic_load,
	output logic count_en,
	output logic count_up,
	output logic op_end
);
	import fpm_pkg::*;

	seq_state_t state;
	seq_state_t state_nx;
	logic is_af_sf;
	logic is_float;

	assign is_af_sf = (op == OP_AF) || (op == OP_SF);
	assign is_float = is_af_sf || (op == OP_MF) || (op == OP_DF);

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			state <= S_IDLE;
		end else begin
			state <= state_nx;
		end
	end

	always_comb begin
		state_nx = state;
		case (state)
			S_IDLE: if (start && pufa) state_nx = S_WAIT_A;
			// op is valid here, fixed point ops end at once
			S_WAIT_A: begin
				if (!is_float) begin
					state_nx = S_END;
				end else if (lkb) begin
					state_nx = S_MOVE_B;
				end
			end
			S_MOVE_B: state_nx = S_WAIT_B;
			S_WAIT_B: if (lkb) state_nx = S_EXEC;
			S_EXEC: begin
				if (is_af_sf && !bus.over_limit) begin
					state_nx = S_ALIGN;
				end else begin
					state_nx = S_END;
				end
			end
			S_ALIGN: if (!fic_nz) state_nx = S_END;
			default: state_nx = S_IDLE;
		endcase
	end

	assign bus.load_d = lkb && (((state == S_WAIT_A) && is_float) || (state == S_WAIT_B));
	assign bus.move_b = (state == S_MOVE_B);
	assign bus.exec = (state == S_EXEC);

	// mf adds, everything else forms Bx - A
	always_comb begin
		if (state != S_EXEC) begin
			bus.bus_mode = BB_ZERO;
			bus.carry_in = 1'b0;
		end else if (op == OP_MF) begin
			bus.bus_mode = BB_TRUE;
			bus.carry_in = 1'b0;
		end else begin
			bus.bus_mode = BB_INV;
			bus.carry_in = 1'b1;
		end
	end

	assign fic_load = bus.exec && is_af_sf && !bus.over_limit;
	assign count_en = (state == S_ALIGN) && fic_nz;
	assign count_up = wdt;
	assign op_end = (state == S_END);

endmodule

// ==== tests/fpm_props.sv ====
`timescale 1ns/1ps

module fpm_props (
	input logic f2strob,
	input logic _0_d_,
	input fpm_pkg::seq_state_t state,
	input logic count_en,
	input logic fic_nz,
	input logic op_end
);
	import fpm_pkg::*;

	// end marker is a single cycle wide
	a_end_pulse: assert property (@(posedge f2strob) disable iff (!_0_d_)
		op_end |=> !op_end)
		else $error("op_end stayed high for more than one cycle");

	// counter only steps while aligning
	a_count_in_align: assert property (@(posedge f2strob) disable iff (!_0_d_)
		count_en |-> (state == S_ALIGN))
		else $error("count_en active outside S_ALIGN");

	a_aligned_at_end: assert property (@(posedge f2strob) disable iff (!_0_d_)
		$rose(op_end) |-> !fic_nz)
		else $error("op_end rose with the alignment counter still nonzero");

	a_end_in_reset: assert property (@(posedge f2strob) !_0_d_ |-> !op_end)
		else $error("op_end high while in reset");

endmodule

bind fpm_seq fpm_props u_props (
	.f2strob (f2strob),
	._0_d_ (_0_d_),
	.state (state),
	.count_en (count_en),
	.fic_nz (fic_nz),
	.op_end (op_end)
);

// ==== tests/fpm_stimulus.txt ====
# pufa ir A Bx d_2 d_1 d g wdt v_f z_f m_f, hex; ir 0..7 = ad sd mw dw af sf mf df
# fixed-point and rejected lines expect the values held from the line before
1 6 05 03 0 0 08 0 0 0 0 0
1 6 70 40 0 0 b0 0 0 1 0 0
1 6 80 f0 1 1 70 0 0 1 0 1
1 6 fb 05 0 0 00 0 0 0 1 0
1 6 f0 fd 1 1 ed 0 0 0 0 1
1 7 03 0a 0 0 07 0 0 0 0 0
1 7 0a 03 1 1 f9 0 0 0 0 1
1 7 81 7f 0 0 fe 0 0 1 0 0
1 7 22 22 0 0 00 0 0 0 1 0
1 4 10 15 0 0 05 0 0 0 0 0
1 5 15 10 1 1 fb 0 1 0 0 1
1 4 07 07 0 0 00 0 0 0 1 0
1 5 00 27 0 0 27 0 0 0 0 0
1 4 00 28 0 0 28 1 0 0 0 0
1 4 50 b0 1 1 60 1 1 0 0 1
1 0 00 00 1 1 60 1 1 0 0 1
1 2 00 00 1 1 60 1 1 0 0 1
1 3 00 00 1 1 60 1 1 0 0 1
0 6 00 00 1 1 60 1 1 0 0 1
1 1 00 00 1 1 60 1 1 0 0 1

// ==== tests/fpm_tb.sv ====
`timescale 1ns/1ps
`include "fpm_defs.svh"

module fpm_tb;

	localparam int CLK_PERIOD = 10;
	localparam int OP_CYCLES = 200;
	localparam int N_RANDOM = 6;

	// one operation with its expected 10-bit result and flags {g, wdt, v_f, z_f, m_f}
	typedef struct packed {
		logic pf;
		logic [2:0] opn;
		logic [7:0] a;
		logic [7:0] bx;
		logic [9:0] r;
		logic [4:0] fl;
	} vec_t;

	logic f2strob;
	logic _0_d_;
	logic start;
	logic [0:2] ir;
	logic pufa;
	logic lkb;
	logic [7:0] w;
	logic [7:0] d;
	logic d_1;
	logic d_2;
	logic g;
	logic wdt;
	logic v_f;
	logic z_f;
	logic m_f;
	logic af_sf;
	logic mw_mf;
	logic dw_df;
	logic ad_sd;
	logic op_end;

	vec_t vecs[$];
	int n_ops = 0;
	integer seed;
	// group lines of the last accepted op
	logic [3:0] held_group;

	fpm dut (.*);

	initial begin
		f2strob = 1'b0;
		forever #(CLK_PERIOD / 2) f2strob = ~f2strob;
	end

	// watchdog sized once the operation count is known
	initial begin
		wait (n_ops > 0);
		#((n_ops + 1) * OP_CYCLES * CLK_PERIOD);
		$display("timeout: op_end never arrived for the current operation");
		$display("Simulation failed");
		$fatal(1);
	end

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH at %0t: %s expected %0h actual %0h",
				$time, name, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	function automatic logic [9:0] magnitude(input logic [9:0] r);
		return r[9] ? (~r + 10'd1) : r;
	endfunction

	// expected result from the operation rules
	function automatic vec_t predict(input logic [2:0] opn, input logic [7:0] a,
		input logic [7:0] bx);
		vec_t v;
		logic [9:0] ea;
		logic [9:0] eb;
		logic add_sub;
		ea = {{2{a[7]}}, a};
		eb = {{2{bx[7]}}, bx};
		add_sub = (opn == 3'd4) || (opn == 3'd5);
		v.pf = 1'b1;
		v.opn = opn;
		v.a = a;
		v.bx = bx;
		v.r = (opn == 3'd6) ? ea + eb : eb - ea;
		v.fl[4] = add_sub && (magnitude(v.r) >= `FPM_ALIGN_LIMIT);
		v.fl[3] = add_sub && v.r[9];
		v.fl[2] = !add_sub && !((v.r[9] == v.r[8]) && (v.r[8] == v.r[7]));
		v.fl[1] = (v.r == 10'd0);
		v.fl[0] = v.r[9];
		return v;
	endfunction

	// {af_sf, mw_mf, dw_df, ad_sd}
	function automatic logic [3:0] group_bits(input logic [2:0] opn);
		case (opn)
			3'd0, 3'd1: return 4'b0001;
			3'd2, 3'd6: return 4'b0100;
			3'd3, 3'd7: return 4'b0010;
			default: return 4'b1000;
		endcase
	endfunction

	task automatic read_vectors();
		int fd;
		int code;
		string line;
		int pf_i, ir_i, a_i, bx_i, d2_i, d1_i, d_i, g_i, wdt_i, v_i, z_i, m_i;
		vec_t v;
		fd = $fopen("tests/fpm_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open stimulus file tests/fpm_stimulus.txt");
			$display("Simulation failed");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2 || line[0] == "#") begin
				continue;
			end
			code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", pf_i, ir_i,
				a_i, bx_i, d2_i, d1_i, d_i, g_i, wdt_i, v_i, z_i, m_i);
			if (code == 12) begin
				v.pf = pf_i[0];
				v.opn = ir_i[2:0];
				v.a = a_i[7:0];
				v.bx = bx_i[7:0];
				v.r = {d2_i[0], d1_i[0], d_i[7:0]};
				v.fl = {g_i[0], wdt_i[0], v_i[0], z_i[0], m_i[0]};
				vecs.push_back(v);
			end
		end
		$fclose(fd);
	endtask

	// cycles from the last drive until op_end is seen
	task automatic wait_end(output int n);
		n = 0;
		do begin
			@(posedge f2strob);
			#1;
			start = 1'b0;
			lkb = 1'b0;
			n++;
		end while (!op_end);
	endtask

	task automatic check_outputs(input vec_t v);
		check("d", v.r[7:0], d);
		check("d_1", v.r[8], d_1);
		check("d_2", v.r[9], d_2);
		check("g", v.fl[4], g);
		check("wdt", v.fl[3], wdt);
		check("v_f", v.fl[2], v_f);
		check("z_f", v.fl[1], z_f);
		check("m_f", v.fl[0], m_f);
	endtask

	task automatic run_op(input vec_t v);
		int n;
		int exp_n;
		@(posedge f2strob);
		#1;
		start = 1'b1;
		pufa = v.pf;
		ir = v.opn;
		if (!v.pf) begin
			// rejected start must leave the unit idle
			repeat (10) begin
				@(posedge f2strob);
				#1;
				start = 1'b0;
				check("op_end", 1'b0, op_end);
			end
			check("group outputs", held_group, {af_sf, mw_mf, dw_df, ad_sd});
		end else begin
			if (v.opn >= 3'd4) begin
				@(posedge f2strob);
				#1;
				start = 1'b0;
				lkb = 1'b1;
				w = v.a;
				@(posedge f2strob);
				#1;
				lkb = 1'b0;
				repeat (2) @(posedge f2strob);
				#1;
				lkb = 1'b1;
				w = v.bx;
			end
			wait_end(n);
			// exec follows the second load and alignment adds |diff| + 1 steps
			if (v.opn < 3'd4 || v.opn >= 3'd6 || v.fl[4]) begin
				exp_n = 2;
			end else begin
				exp_n = magnitude(v.r) + 3;
			end
			check("op_end delay", exp_n, n);
			check("group outputs", group_bits(v.opn), {af_sf, mw_mf, dw_df, ad_sd});
			held_group = group_bits(v.opn);
		end
		check_outputs(v);
	endtask

	initial begin
		logic [2:0] opn;
		logic [7:0] a;
		logic [7:0] bx;
		_0_d_ = 1'b0;
		start = 1'b0;
		ir = 3'd0;
		pufa = 1'b0;
		lkb = 1'b0;
		w = 8'd0;
		held_group = 4'b0000;
		read_vectors();
		seed = 32'ha48c592c;
		repeat (N_RANDOM) begin
			opn = 3'd4 + 3'($random(seed) & 3);
			a = 8'($random(seed));
			bx = 8'($random(seed));
			vecs.push_back(predict(opn, a, bx));
		end
		n_ops = vecs.size();
		repeat (5) @(posedge f2strob);
		#1;
		_0_d_ = 1'b1;
		check("op_end", 1'b0, op_end);
		check("group outputs", held_group, {af_sf, mw_mf, dw_df, ad_sd});
		check_outputs('0);
		foreach (vecs[i]) begin
			run_op(vecs[i]);
		end
		$display("Simulation passed");
		$finish;
	end

endmodule
